//--- filelist.f
src/maxflow_pkg.sv
src/l1_read_if.sv
src/logged_store_if.sv
src/l1_reader.sv
src/logged_store.sv
src/task_fsm.sv
src/maxflow_task_unit.sv
testbench/l1_mem_model.sv
testbench/tb_maxflow.sv

//--- Bender.yml
package:
  name: maxflow_task_unit

sources:
  - src/maxflow_pkg.sv
  - src/l1_read_if.sv
  - src/logged_store_if.sv
  - src/l1_reader.sv
  - src/logged_store.sv
  - src/task_fsm.sv
  - src/maxflow_task_unit.sv
  - target: test
    files:
      - testbench/l1_mem_model.sv
      - testbench/tb_maxflow.sv

//--- testbench/tb_maxflow.sv
module tb_maxflow import maxflow_pkg::*; ();

   localparam int NUM_TASKS = 60;
   localparam int MAX_BEATS = 2;
   localparam int DEPTH     = 1024;

   logic        clk = 1'b0;
   logic        rstn;
   logic        start;
   task_t       task_in;
   logic        done;
   logic        idle;
   task_t       task_out;
   logic        task_out_valid;
   logic        task_out_ready;
   undo_entry_t undo_entry;
   logic        undo_valid;
   logic        undo_ready;
   logic        arvalid, arready, rvalid, rready, rlast;
   word_t       araddr, rdata, awaddr, wdata;
   logic [7:0]  arlen;
   logic        awvalid, awready, wvalid, wlast, bvalid, bready;

   word_t       model_mem [0:DEPTH-1];
   logic [39:0] exp_rd [$];     // {addr, len}
   logic [63:0] exp_wr [$];     // {addr, data}
   undo_entry_t exp_undo [$];
   task_t       exp_task [$];
   logic        model_loaded = 1'b0;
   integer      seed = 73;
   integer      stall_seed = 73;
   int          done_count = 0;
   logic        prev_tv, prev_tr, prev_uv, prev_ur, prev_av, prev_ar, prev_done;
   logic        prev_aw, prev_awr;
   task_t       prev_task;
   undo_entry_t prev_undo;
   word_t       prev_araddr;
   logic [63:0] prev_wr;

   always #2 clk = ~clk;

   maxflow_task_unit #(.MAX_BEATS(MAX_BEATS)) maxflow_task_unit_inst (
      .clk(clk), .rstn(rstn), .start(start), .task_in(task_in), .done(done), .idle(idle),
      .task_out(task_out), .task_out_valid(task_out_valid), .task_out_ready(task_out_ready),
      .undo_entry(undo_entry), .undo_valid(undo_valid), .undo_ready(undo_ready),
      .arvalid(arvalid), .arready(arready), .araddr(araddr), .arlen(arlen),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wdata(wdata), .wlast(wlast), .bvalid(bvalid), .bready(bready)
   );

   l1_mem_model #(.DEPTH(DEPTH)) mem_model_inst (
      .clk(clk), .rstn(rstn), .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .arlen(arlen), .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .wvalid(wvalid),
      .wdata(wdata), .bvalid(bvalid)
   );

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_equal(input string name, input logic [131:0] expected,
                              input logic [131:0] actual);
      assert (expected === actual) else begin
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   // undo entry with the old value ahead of the new word
   task automatic store(input word_t addr, input word_t data);
      exp_undo.push_back({model_mem[addr >> 2], addr});
      exp_wr.push_back({addr, data});
      model_mem[addr >> 2] = data;
   endtask

   task automatic predict(input task_t t);
      word_t vaddr;
      word_t faddr;
      word_t new_exc;
      vaddr = (word_t'(model_mem[5][30:0]) << 2) + (word_t'(t.hint[30:0]) << 6);
      faddr = vaddr + ((32'd6 + t.args[3:0]) << 2);
      if (!model_loaded) begin
         exp_rd.push_back({32'd20, 8'd0});   // header word on the first start only
         model_loaded = 1'b1;
      end
      case (t.ttype)
         4'd1: begin
            exp_rd.push_back({vaddr + 32'd16, 8'd0});
            exp_task.push_back({32'd0, model_mem[(vaddr + 32'd16) >> 2], 4'd2,
                                t.args[31:0], t.ts});
         end
         4'd3: begin
            exp_rd.push_back({vaddr, 8'd1});
            exp_rd.push_back({faddr, 8'd0});
            store(faddr, model_mem[faddr >> 2] - t.args[63:32]);
            new_exc = model_mem[vaddr >> 2] + t.args[63:32];
            store(vaddr, new_exc);
            if ($signed(new_exc) > 0 && model_mem[(vaddr >> 2) + 1][0] == 1'b0) begin
               exp_undo.push_back({32'd0, vaddr + 32'd4});   // active logged as clear
               exp_wr.push_back({vaddr + 32'd4, 32'd1});
               model_mem[(vaddr >> 2) + 1] = 32'd1;
               exp_task.push_back({t.ts, 32'd0, 4'd0, t.hint, t.ts});
            end
         end
         default: ;   // unknown type does nothing
      endcase
   endtask

   always @(posedge clk) begin
      task_out_ready <= ($random(stall_seed) & 3) != 0;
      undo_ready     <= ($random(stall_seed) & 1) != 0;
   end

   always @(posedge clk) begin
      if (rstn) begin
         if (done) begin
            done_count++;
         end
         assert (!(done && prev_done)) else begin
            $display("done stayed high for more than one cycle");
            abort_run();
         end
         if (arvalid && arready) begin
            assert (exp_rd.size() > 0) else begin
               $display("unexpected read at address %h", araddr);
               abort_run();
            end
            check_equal("read request", exp_rd.pop_front(), {araddr, arlen});
         end
         if (undo_valid && undo_ready) begin
            assert (exp_undo.size() > 0) else begin
               $display("unexpected undo log entry for address %h", undo_entry.addr);
               abort_run();
            end
            check_equal("undo entry", exp_undo.pop_front(), undo_entry);
         end
         if (awvalid && awready) begin
            assert (exp_wr.size() > 0 && exp_undo.size() < exp_wr.size()) else begin
               $display("memory write at %h is unexpected or came before its undo entry",
                        awaddr);
               abort_run();
            end
            assert (wvalid && wlast) else begin
               $display("write data was not presented with the write address");
               abort_run();
            end
            check_equal("memory write", exp_wr.pop_front(), {awaddr, wdata});
         end
         if (task_out_valid && task_out_ready) begin
            assert (exp_task.size() > 0) else begin
               $display("unexpected task output of type %0d", task_out.ttype);
               abort_run();
            end
            check_equal("task output", exp_task.pop_front(), task_out);
         end
         assert (!(prev_tv && !prev_tr) || (task_out_valid && task_out === prev_task)) else begin
            $display("task output dropped or changed while stalled");
            abort_run();
         end
         assert (!(prev_uv && !prev_ur) || (undo_valid && undo_entry === prev_undo)) else begin
            $display("undo entry dropped or changed while stalled");
            abort_run();
         end
         assert (!(prev_av && !prev_ar) || (arvalid && araddr === prev_araddr)) else begin
            $display("read address dropped or changed while stalled");
            abort_run();
         end
         assert (!(prev_aw && !prev_awr) || (awvalid && {awaddr, wdata} === prev_wr)) else begin
            $display("memory write dropped or changed while stalled");
            abort_run();
         end
      end
      prev_tv     = task_out_valid;
      prev_tr     = task_out_ready;
      prev_task   = task_out;
      prev_uv     = undo_valid;
      prev_ur     = undo_ready;
      prev_undo   = undo_entry;
      prev_av     = arvalid;
      prev_ar     = arready;
      prev_araddr = araddr;
      prev_aw     = awvalid;
      prev_awr    = awready;
      prev_wr     = {awaddr, wdata};
      prev_done   = done;
   end

   initial begin
      repeat (NUM_TASKS * 200) @(posedge clk);
      $display("timeout: the tasks did not finish within %0d cycles", NUM_TASKS * 200);
      abort_run();
   end

   initial begin
      task_t t;
      int    sel;
      rstn           = 1'b0;
      start          = 1'b0;
      task_in        = '0;
      task_out_ready = 1'b0;
      undo_ready     = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         model_mem[i] = $random(seed);
         if (i % 16 == 1) begin
            model_mem[i] = model_mem[i] & 32'd1;   // active flag word
         end
      end
      model_mem[5] = 32'h100;   // vertex records from byte 0x400
      for (int i = 0; i < DEPTH; i++) begin
         mem_model_inst.mem[i] = model_mem[i];
      end
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      assert (idle && !done && !arvalid && !rready && !awvalid && !wvalid &&
              !task_out_valid && !undo_valid && bready) else begin
         $display("control outputs were not inactive after reset");
         abort_run();
      end
      for (int n = 0; n < NUM_TASKS; n++) begin
         sel     = ($random(seed) & 32'h7fff_ffff) % 3;
         t.ttype = (sel == 0) ? 4'd1 : (sel == 1) ? 4'd3 : 4'hA;
         t.hint  = $random(seed) & 32'h8000_000F;   // vertex 0..15 with a junk top bit
         t.args  = {$random(seed), $random(seed)};
         t.ts    = $random(seed);
         predict(t);
         @(posedge clk);
         start   <= 1'b1;
         task_in <= t;
         do begin
            @(posedge clk);
         end while (!idle);
         start <= 1'b0;
         do begin
            @(posedge clk);
         end while (!done);
         assert (exp_rd.size() == 0 && exp_wr.size() == 0 && exp_undo.size() == 0 &&
                 exp_task.size() == 0) else begin
            $display("task %0d ended with expected traffic still missing", n);
            abort_run();
         end
      end
      repeat (4) @(posedge clk);
      check_equal("done count", NUM_TASKS, done_count);
      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- testbench/l1_mem_model.sv
module l1_mem_model import maxflow_pkg::*; #(
   parameter int DEPTH = 512
) (
   input  logic       clk,
   input  logic       rstn,
   input  logic       arvalid,
   output logic       arready,
   input  word_t      araddr,
   input  logic [7:0] arlen,
   output logic       rvalid,
   input  logic       rready,
   output word_t      rdata,
   output logic       rlast,
   input  logic       awvalid,
   output logic       awready,
   input  word_t      awaddr,
   input  logic       wvalid,
   input  word_t      wdata,
   output logic       bvalid
);

   word_t      mem [0:DEPTH-1];   // filled by the testbench
   integer     seed = 73;
   logic       busy;
   word_t      base;              // word index of the burst
   logic [7:0] len;
   logic [7:0] beat;              // beats presented so far

   initial begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rdata   = '0;
      rlast   = 1'b0;
      awready = 1'b0;
      bvalid  = 1'b0;
      busy    = 1'b0;
   end

   always @(posedge clk) begin
      if (!rstn) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rlast   <= 1'b0;
         awready <= 1'b0;
         bvalid  <= 1'b0;
         busy    <= 1'b0;
      end else begin
         arready <= !busy && (($random(seed) & 3) != 0);
         awready <= ($random(seed) & 1) != 0;
         bvalid  <= awvalid && awready;   // one response per write
         if (awvalid && awready && wvalid) begin
            mem[awaddr >> 2] <= wdata;
         end
         if (arvalid && arready) begin
            busy <= 1'b1;
            base <= araddr >> 2;
            len  <= arlen;
            beat <= '0;
         end
         if (busy && (!rvalid || rready)) begin
            if (rvalid && rlast) begin
               rvalid <= 1'b0;
               rlast  <= 1'b0;
               busy   <= 1'b0;
            end else if (beat <= len && ($random(seed) & 3) != 0) begin
               rvalid <= 1'b1;
               rdata  <= mem[base + beat];
               rlast  <= (beat == len);
               beat   <= beat + 1'b1;
            end else begin
               rvalid <= 1'b0;   // stall between beats
            end
         end
      end
   end

endmodule

//--- src/maxflow_task_unit.sv
module maxflow_task_unit import maxflow_pkg::*; #(
   parameter int MAX_BEATS = 2
) (
   input  logic         clk,
   input  logic         rstn,

   input  logic         start,
   input  task_t        task_in,
   output logic         done,
   output logic         idle,

   output task_t        task_out,
   output logic         task_out_valid,
   input  logic         task_out_ready,

   output undo_entry_t  undo_entry,
   output logic         undo_valid,
   input  logic         undo_ready,

   output logic         arvalid,
   input  logic         arready,
   output word_t        araddr,
   output logic [7:0]   arlen,
   input  logic         rvalid,
   output logic         rready,
   input  word_t        rdata,
   input  logic         rlast,
   output logic         awvalid,
   input  logic         awready,
   output word_t        awaddr,
   output logic         wvalid,
   output word_t        wdata,
   output logic         wlast,
   input  logic         bvalid,
   output logic         bready
);

   l1_read_if #(.MAX_BEATS(MAX_BEATS)) rd_bus ();
   logged_store_if st_bus ();

   task_fsm task_fsm_inst (
      .clk            (clk),
      .rstn           (rstn),
      .start          (start),
      .task_in        (task_in),
      .done           (done),
      .idle           (idle),
      .task_out       (task_out),
      .task_out_valid (task_out_valid),
      .task_out_ready (task_out_ready),
      .rd             (rd_bus.ctrl),
      .st             (st_bus.ctrl)
   );

   l1_reader #(.MAX_BEATS(MAX_BEATS)) l1_reader_inst (
      .clk     (clk),
      .rstn    (rstn),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .arlen   (arlen),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rlast   (rlast),
      .rd      (rd_bus.engine)
   );

   logged_store logged_store_inst (
      .clk        (clk),
      .rstn       (rstn),
      .undo_valid (undo_valid),
      .undo_ready (undo_ready),
      .undo_entry (undo_entry),
      .awvalid    (awvalid),
      .awready    (awready),
      .awaddr     (awaddr),
      .wvalid     (wvalid),
      .wdata      (wdata),
      .wlast      (wlast),
      .st         (st_bus.engine)
   );

   assign bready = 1'b1;   // write responses are dropped

endmodule

//--- src/task_fsm.sv
module task_fsm import maxflow_pkg::*; (
   input  logic          clk,
   input  logic          rstn,
   input  logic          start,
   input  task_t         task_in,
   output logic          done,
   output logic          idle,
   output task_t         task_out,
   output logic          task_out_valid,
   input  logic          task_out_ready,
   l1_read_if.ctrl       rd,
   logged_store_if.ctrl  st
);

   typedef enum logic [4:0] {
      ST_IDLE, ST_HDR_RD, ST_HDR_WAIT, ST_DISPATCH,
      ST_GH_RD, ST_GH_WAIT, ST_GH_EMIT,
      ST_RV_VTX_RD, ST_RV_VTX_WAIT, ST_RV_FLOW_RD, ST_RV_FLOW_WAIT,
      ST_RV_FLOW_ST, ST_RV_FLOW_STW, ST_RV_EXC_ST, ST_RV_EXC_STW,
      ST_RV_ACT_ST, ST_RV_ACT_STW, ST_RV_EMIT, ST_DONE
   } state_t;

   state_t state, state_next;
   logic   loaded;     // header base valid
   task_t  cur_task;
   word_t  vtx_base;
   word_t  excess;
   logic   active;
   word_t  flow;
   word_t  vtx_addr;
   word_t  flow_addr;
   word_t  amount;
   word_t  excess_new;

   assign vtx_addr   = vtx_base + (word_t'(cur_task.hint[30:0]) << VTX_RECORD_SHIFT);
   assign flow_addr  = vtx_addr +
                       ((word_t'(VTX_FLOW_BASE_WORD) + word_t'(cur_task.args[3:0])) << 2);
   assign amount     = cur_task.args[63:32];
   assign excess_new = excess + amount;

   assign done = (state == ST_DONE);
   assign idle = (state == ST_IDLE);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= ST_IDLE;
         loaded <= 1'b0;
      end else begin
         state <= state_next;
         if (state == ST_HDR_WAIT && rd.done) begin
            loaded <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && start) begin
         cur_task <= task_in;
      end
      if (state == ST_HDR_WAIT && rd.done) begin
         vtx_base <= word_t'(rd.words[0][30:0]) << 2;   // word index to byte address
      end
      if (state == ST_RV_VTX_WAIT && rd.done) begin
         excess <= rd.words[0];
         active <= rd.words[1][0];
      end
      if (state == ST_RV_FLOW_WAIT && rd.done) begin
         flow <= rd.words[0];
      end
   end

   always_comb begin
      state_next     = state;
      rd.req         = 1'b0;
      rd.addr        = '0;
      rd.len         = 8'd0;
      st.req         = 1'b0;
      st.addr        = '0;
      st.old_data    = '0;
      st.new_data    = '0;
      task_out_valid = 1'b0;
      task_out       = '0;
      case (state)
         ST_IDLE: begin
            if (start) begin
               state_next = loaded ? ST_DISPATCH : ST_HDR_RD;
            end
         end
         ST_HDR_RD: begin
            rd.req     = 1'b1;
            rd.addr    = HDR_VERTEX_BASE_ADDR;
            state_next = ST_HDR_WAIT;
         end
         ST_DISPATCH: begin
            case (cur_task.ttype)
               TT_GET_HEIGHT: state_next = ST_GH_RD;
               TT_RECEIVE:    state_next = ST_RV_VTX_RD;
               default:       state_next = ST_DONE;   // no memory traffic
            endcase
         end
         ST_GH_RD: begin
            rd.req     = 1'b1;
            rd.addr    = vtx_addr + VTX_HEIGHT_OFS;
            state_next = ST_GH_WAIT;
         end
         ST_GH_EMIT: begin
            task_out_valid = 1'b1;
            task_out.ttype = TT_PUSH;
            task_out.hint  = cur_task.args[31:0];
            task_out.args  = {32'd0, rd.words[0]};   // height still in the buffer
            task_out.ts    = cur_task.ts;
            if (task_out_ready) begin
               state_next = ST_DONE;
            end
         end
         ST_RV_VTX_RD: begin
            rd.req     = 1'b1;
            rd.addr    = vtx_addr + VTX_EXCESS_OFS;
            rd.len     = 8'd1;   // excess, active
            state_next = ST_RV_VTX_WAIT;
         end
         ST_RV_FLOW_RD: begin
            rd.req     = 1'b1;
            rd.addr    = flow_addr;
            state_next = ST_RV_FLOW_WAIT;
         end
         ST_RV_FLOW_ST: begin
            st.req      = 1'b1;
            st.addr     = flow_addr;
            st.old_data = flow;
            st.new_data = flow - amount;
            state_next  = ST_RV_FLOW_STW;
         end
         ST_RV_EXC_ST: begin
            st.req      = 1'b1;
            st.addr     = vtx_addr + VTX_EXCESS_OFS;
            st.old_data = excess;
            st.new_data = excess_new;
            state_next  = ST_RV_EXC_STW;
         end
         ST_RV_EXC_STW: begin
            if (st.done) begin
               if ($signed(excess_new) > 0 && !active) begin
                  state_next = ST_RV_ACT_ST;   // vertex becomes active
               end else begin
                  state_next = ST_DONE;
               end
            end
         end
         ST_RV_ACT_ST: begin
            st.req      = 1'b1;
            st.addr     = vtx_addr + VTX_ACTIVE_OFS;
            st.new_data = 32'd1;
            state_next  = ST_RV_ACT_STW;
         end
         ST_RV_EMIT: begin
            task_out_valid = 1'b1;
            task_out.ttype = TT_DISCHARGE;
            task_out.hint  = cur_task.hint;
            task_out.args  = {cur_task.ts, 32'd0};
            task_out.ts    = cur_task.ts;
            if (task_out_ready) begin
               state_next = ST_DONE;
            end
         end
         ST_HDR_WAIT:     if (rd.done) state_next = ST_DISPATCH;
         ST_GH_WAIT:      if (rd.done) state_next = ST_GH_EMIT;
         ST_RV_VTX_WAIT:  if (rd.done) state_next = ST_RV_FLOW_RD;
         ST_RV_FLOW_WAIT: if (rd.done) state_next = ST_RV_FLOW_ST;
         ST_RV_FLOW_STW:  if (st.done) state_next = ST_RV_EXC_ST;
         ST_RV_ACT_STW:   if (st.done) state_next = ST_RV_EMIT;
         ST_DONE:         state_next = ST_IDLE;
         default:         state_next = ST_IDLE;
      endcase
   end

endmodule

//--- src/logged_store.sv
module logged_store import maxflow_pkg::*; (
   input  logic          clk,
   input  logic          rstn,
   output logic          undo_valid,
   input  logic          undo_ready,
   output undo_entry_t   undo_entry,
   output logic          awvalid,
   input  logic          awready,
   output word_t         awaddr,
   output logic          wvalid,
   output word_t         wdata,
   output logic          wlast,
   logged_store_if.engine st
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOG,
      ST_WRITE
   } state_t;

   state_t state;
   word_t  addr_q;
   word_t  old_q;
   word_t  new_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state   <= ST_IDLE;
         st.done <= 1'b0;
      end else begin
         st.done <= (state == ST_WRITE) && awready;
         case (state)
            ST_IDLE: begin
               if (st.req) begin
                  state <= ST_LOG;
               end
            end
            ST_LOG: begin
               if (undo_ready) begin
                  state <= ST_WRITE;   // log entry taken before the write
               end
            end
            ST_WRITE: begin
               if (awready) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && st.req) begin
         addr_q <= st.addr;
         old_q  <= st.old_data;
         new_q  <= st.new_data;
      end
   end

   assign undo_valid          = (state == ST_LOG);
   assign undo_entry.old_data = old_q;
   assign undo_entry.addr     = addr_q;

   // single beat with the data riding on the address
   assign awvalid = (state == ST_WRITE);
   assign awaddr  = addr_q;
   assign wvalid  = awvalid;
   assign wdata   = new_q;
   assign wlast   = awvalid;

endmodule

//--- src/l1_reader.sv
module l1_reader import maxflow_pkg::*; #(
   parameter int MAX_BEATS = 2
) (
   input  logic        clk,
   input  logic        rstn,
   output logic        arvalid,
   input  logic        arready,
   output word_t       araddr,
   output logic [7:0]  arlen,
   input  logic        rvalid,
   output logic        rready,
   input  word_t       rdata,
   input  logic        rlast,
   l1_read_if.engine   rd
);

   localparam int BEAT_W = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;

   logic [BEAT_W-1:0] beat;   // next buffer slot

   always_ff @(posedge clk) begin
      if (!rstn) begin
         arvalid <= 1'b0;
         rready  <= 1'b0;
         beat    <= '0;
         rd.done <= 1'b0;
      end else begin
         rd.done <= rvalid && rready && rlast;
         if (rd.req) begin
            arvalid <= 1'b1;
            beat    <= '0;
         end else if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;   // open the data phase
         end
         if (rvalid && rready) begin
            beat <= beat + 1'b1;
            if (rlast) begin
               rready <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd.req) begin
         araddr <= rd.addr;
         arlen  <= rd.len;
      end
      if (rvalid && rready) begin
         rd.words[beat] <= rdata;
      end
   end

endmodule

//--- src/logged_store_if.sv
interface logged_store_if import maxflow_pkg::*; ();

   logic  req;
   word_t addr;
   word_t old_data;   // value before the store for the undo log
   word_t new_data;
   logic  done;

   modport ctrl (
      output req, addr, old_data, new_data,
      input  done
   );

   modport engine (
      input  req, addr, old_data, new_data,
      output done
   );

endinterface

//--- src/l1_read_if.sv
interface l1_read_if import maxflow_pkg::*; #(
   parameter int MAX_BEATS = 2
) ();

   logic                  req;
   word_t                 addr;
   logic [7:0]            len;     // beats minus one
   logic                  done;
   word_t [MAX_BEATS-1:0] words;   // slot i holds beat i

   modport ctrl (
      output req, addr, len,
      input  done, words
   );

   modport engine (
      input  req, addr, len,
      output done, words
   );

endinterface

//--- src/maxflow_pkg.sv
package maxflow_pkg;

   typedef logic [31:0] word_t;   // memory word and byte address
   typedef logic [31:0] ts_t;
   typedef logic [3:0]  ttype_t;

   // same field order as the task queue word
   typedef struct packed {
      logic [63:0] args;
      ttype_t      ttype;
      word_t       hint;
      ts_t         ts;
   } task_t;

   typedef struct packed {
      word_t old_data;
      word_t addr;
   } undo_entry_t;

   localparam ttype_t TT_DISCHARGE  = 4'd0;
   localparam ttype_t TT_GET_HEIGHT = 4'd1;
   localparam ttype_t TT_PUSH       = 4'd2;
   localparam ttype_t TT_RECEIVE    = 4'd3;

   // byte offsets inside a 64-byte vertex record
   localparam word_t VTX_EXCESS_OFS = 32'd0;
   localparam word_t VTX_ACTIVE_OFS = 32'd4;
   localparam word_t VTX_HEIGHT_OFS = 32'd16;

   localparam int VTX_FLOW_BASE_WORD = 6;   // flow[0] word index
   localparam int VTX_RECORD_SHIFT   = 6;

   localparam word_t HDR_VERTEX_BASE_ADDR = 32'd20;   // header word 5

endpackage
